//--- viterbi_code_pkg.sv
`default_nettype none

package viterbi_code_pkg;

   localparam int STATE_W    = 3;
   localparam int NUM_STATES = 8;

   // taps over the register {input bit, state}
   localparam logic [3:0] GEN0 = 4'b1111;
   localparam logic [3:0] GEN1 = 4'b1101;

   typedef logic [1:0]            symbol_t;    // {GEN0 parity, GEN1 parity}
   typedef logic [1:0]            bm_t;        // hamming distance 0..2
   typedef logic [STATE_W-1:0]    state_t;     // last three inputs, newest in bit 2
   typedef logic [NUM_STATES-1:0] decision_t;  // bit n set: state n came from odd pred

   // code pair sent when input bit b leaves state s
   function automatic symbol_t code_symbol(input logic b, input state_t s);
      logic [3:0] sr;
      sr = {b, s};
      return {^(sr & GEN0), ^(sr & GEN1)};
   endfunction

   function automatic bm_t hamming(input symbol_t a, input symbol_t b);
      symbol_t diff;
      diff = a ^ b;
      return bm_t'(diff[1]) + bm_t'(diff[0]);
   endfunction

endpackage

`default_nettype wire

//--- viterbi_mem_pkg.sv
`default_nettype none

package viterbi_mem_pkg;

   localparam int NUM_BANKS = 4;

   typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;

   // read banks relative to the write bank
   localparam bank_idx_t TRAIN_OFS  = 2'd3;  // newest full bank
   localparam bank_idx_t DECODE_OFS = 2'd1;  // oldest bank, next to be overwritten

   typedef enum logic [1:0] {
      TB_IDLE,
      TB_TRAIN,
      TB_DECODE
   } tb_phase_e;

endpackage

`default_nettype wire

//--- branch_metric.sv
`timescale 1ns/1ps
`default_nettype none

module branch_metric (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire                                 enable_i,
   input  wire  viterbi_code_pkg::symbol_t     symbol_i,
   output viterbi_code_pkg::bm_t [viterbi_code_pkg::NUM_STATES-1:0] bm0_o,
   output viterbi_code_pkg::bm_t [viterbi_code_pkg::NUM_STATES-1:0] bm1_o,
   output logic                                bm_valid_o
);

   localparam int NS = viterbi_code_pkg::NUM_STATES;

   viterbi_code_pkg::bm_t [NS-1:0] bm0_d;
   viterbi_code_pkg::bm_t [NS-1:0] bm1_d;

   // distance of the symbol to both branches out of every state
   always_comb begin
      viterbi_code_pkg::state_t s;
      for (int i = 0; i < NS; i++) begin
         s        = viterbi_code_pkg::state_t'(i);
         bm0_d[i] = viterbi_code_pkg::hamming(viterbi_code_pkg::code_symbol(1'b0, s),
                                              symbol_i);
         bm1_d[i] = viterbi_code_pkg::hamming(viterbi_code_pkg::code_symbol(1'b1, s),
                                              symbol_i);
      end
   end

   always_ff @(posedge clk) begin
      bm0_o <= bm0_d;
      bm1_o <= bm1_d;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         bm_valid_o <= 1'b0;
      else
         bm_valid_o <= enable_i;  // one symbol per enabled cycle
   end

endmodule

`default_nettype wire

//--- acs_array.sv
`timescale 1ns/1ps
`default_nettype none

module acs_array #(
   parameter int PM_W = 8
) (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire                                 enable_i,
   input  wire  viterbi_code_pkg::bm_t [viterbi_code_pkg::NUM_STATES-1:0] bm0_i,
   input  wire  viterbi_code_pkg::bm_t [viterbi_code_pkg::NUM_STATES-1:0] bm1_i,
   input  wire                                 bm_valid_i,
   output viterbi_code_pkg::decision_t         dec_o,
   output logic                                dec_valid_o
);

   localparam int NS = viterbi_code_pkg::NUM_STATES;

   logic [PM_W-1:0]             pm_q [NS];  // path metrics
   logic [PM_W-1:0]             pm_d [NS];
   logic [NS-1:0]               valid_q;    // state reachable yet
   logic [NS-1:0]               valid_d;
   logic [NS-1:0]               msb;
   logic                        norm;
   viterbi_code_pkg::decision_t dec_d;

   // ------------------------------
   // normalization
   // ------------------------------
   always_comb begin
      for (int n = 0; n < NS; n++)
         msb[n] = pm_q[n][PM_W-1];
   end

   assign norm = &msb;  // all metrics in upper half

   // ------------------------------
   // butterflies
   // ------------------------------
   always_comb begin
      viterbi_code_pkg::state_t s;
      viterbi_code_pkg::state_t p0;
      viterbi_code_pkg::state_t p1;
      logic [PM_W-1:0]          base0;
      logic [PM_W-1:0]          base1;
      logic [PM_W-1:0]          sum0;
      logic [PM_W-1:0]          sum1;
      logic                     sel;
      for (int n = 0; n < NS; n++) begin
         s  = viterbi_code_pkg::state_t'(n);
         p0 = {s[1:0], 1'b0};
         p1 = {s[1:0], 1'b1};

         // drop the common msb before adding
         base0 = norm ? {1'b0, pm_q[p0][PM_W-2:0]} : pm_q[p0];
         base1 = norm ? {1'b0, pm_q[p1][PM_W-2:0]} : pm_q[p1];

         // input bit entering state n is s[2]
         sum0 = base0 + PM_W'(s[2] ? bm1_i[p0] : bm0_i[p0]);
         sum1 = base1 + PM_W'(s[2] ? bm1_i[p1] : bm0_i[p1]);

         // tie keeps the even predecessor
         sel = valid_q[p1] && (!valid_q[p0] || (sum1 < sum0));

         dec_d[n]   = sel;
         pm_d[n]    = sel ? sum1 : sum0;
         valid_d[n] = valid_q[p0] | valid_q[p1];
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         valid_q     <= NS'(1);  // encoder starts in state 0
         pm_q        <= '{default: '0};
         dec_valid_o <= 1'b0;
      end else if (!enable_i) begin
         valid_q     <= NS'(1);
         pm_q        <= '{default: '0};
         dec_valid_o <= 1'b0;
      end else begin
         dec_valid_o <= bm_valid_i;
         if (bm_valid_i) begin
            valid_q <= valid_d;
            pm_q    <= pm_d;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bm_valid_i)
         dec_o <= dec_d;
   end

endmodule

`default_nettype wire

//--- survivor_mem.sv
`timescale 1ns/1ps
`default_nettype none

module survivor_mem #(
   parameter int TB_LEN = 16
) (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire                                 enable_i,
   input  wire  viterbi_code_pkg::decision_t   dec_i,
   input  wire                                 dec_valid_i,
   output logic                                start0_o,
   output logic                                start1_o,
   output viterbi_code_pkg::decision_t         word0_o,
   output viterbi_code_pkg::decision_t         word1_o,
   output logic                                word_valid0_o,
   output logic                                word_valid1_o
);

   localparam int CNT_W = $clog2(TB_LEN);
   localparam int NB    = viterbi_mem_pkg::NUM_BANKS;

   viterbi_code_pkg::decision_t bank_q [NB][TB_LEN];

   logic [CNT_W-1:0]           wr_cnt;      // up, write address
   logic [CNT_W-1:0]           rd_cnt;      // down, read address
   viterbi_mem_pkg::bank_idx_t wr_bank;
   viterbi_mem_pkg::bank_idx_t trn_bank;
   viterbi_mem_pkg::bank_idx_t dec_bank;
   logic                       blk_end;
   logic                       first_done;  // one bank already full
   logic                       start;
   logic                       turn;        // unit to start next
   logic                       have_train;
   logic                       have_dec;

   assign blk_end  = dec_valid_i && (wr_cnt == CNT_W'(TB_LEN - 1));
   assign start    = blk_end && first_done;
   assign trn_bank = wr_bank + viterbi_mem_pkg::TRAIN_OFS;
   assign dec_bank = wr_bank + viterbi_mem_pkg::DECODE_OFS;

   // ------------------------------
   // write side
   // ------------------------------
   always_ff @(posedge clk) begin
      if (dec_valid_i)
         bank_q[wr_bank][wr_cnt] <= dec_i;
   end

   // ------------------------------
   // counters and bank rotation
   // ------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_cnt     <= '0;
         rd_cnt     <= CNT_W'(TB_LEN - 1);
         wr_bank    <= '0;
         first_done <= 1'b0;
         turn       <= 1'b0;
         have_train <= 1'b0;
         have_dec   <= 1'b0;
      end else if (!enable_i) begin
         wr_cnt     <= '0;
         rd_cnt     <= CNT_W'(TB_LEN - 1);
         wr_bank    <= '0;
         first_done <= 1'b0;
         turn       <= 1'b0;
         have_train <= 1'b0;
         have_dec   <= 1'b0;
      end else begin
         if (dec_valid_i) begin
            wr_cnt <= wr_cnt + 1'b1;
            rd_cnt <= rd_cnt - 1'b1;
         end
         if (blk_end) begin
            wr_bank    <= wr_bank + 1'b1;
            first_done <= 1'b1;
         end
         if (start) begin
            turn       <= ~turn;
            have_train <= 1'b1;
            have_dec   <= have_train;  // decode begins one block later
         end
      end
   end

   // ------------------------------
   // start pulses and read routing
   // ------------------------------
   // the unit started last trains, the other one decodes
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         start0_o      <= 1'b0;
         start1_o      <= 1'b0;
         word_valid0_o <= 1'b0;
         word_valid1_o <= 1'b0;
      end else if (!enable_i) begin
         start0_o      <= 1'b0;
         start1_o      <= 1'b0;
         word_valid0_o <= 1'b0;
         word_valid1_o <= 1'b0;
      end else begin
         start0_o      <= start && !turn;
         start1_o      <= start && turn;
         word_valid0_o <= dec_valid_i && (turn ? have_train : have_dec);
         word_valid1_o <= dec_valid_i && (turn ? have_dec : have_train);
      end
   end

   always_ff @(posedge clk) begin
      word0_o <= turn ? bank_q[trn_bank][rd_cnt] : bank_q[dec_bank][rd_cnt];
      word1_o <= turn ? bank_q[dec_bank][rd_cnt] : bank_q[trn_bank][rd_cnt];
   end

endmodule

`default_nettype wire

//--- traceback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module traceback_unit #(
   parameter int TB_LEN = 16
) (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire                                 enable_i,
   input  wire                                 start_i,
   input  wire  viterbi_code_pkg::decision_t   word_i,
   input  wire                                 word_valid_i,
   output logic                                bit_o,
   output logic                                bit_valid_o
);

   localparam int CNT_W = $clog2(TB_LEN);

   viterbi_mem_pkg::tb_phase_e phase_q;
   viterbi_code_pkg::state_t   state_q;  // current trellis state on the path
   logic [CNT_W-1:0]           cnt_q;    // words consumed in this phase
   logic                       step;
   logic                       last;

   assign step = word_valid_i && (phase_q != viterbi_mem_pkg::TB_IDLE);
   assign last = (cnt_q == CNT_W'(TB_LEN - 1));

   // start may coincide with the last decode word of the previous job
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         phase_q     <= viterbi_mem_pkg::TB_IDLE;
         state_q     <= '0;
         cnt_q       <= '0;
         bit_valid_o <= 1'b0;
      end else if (!enable_i) begin
         phase_q     <= viterbi_mem_pkg::TB_IDLE;
         state_q     <= '0;
         cnt_q       <= '0;
         bit_valid_o <= 1'b0;
      end else begin
         bit_valid_o <= word_valid_i && (phase_q == viterbi_mem_pkg::TB_DECODE);
         if (start_i) begin
            phase_q <= viterbi_mem_pkg::TB_TRAIN;
            state_q <= '0;  // arbitrary start, training converges
            cnt_q   <= '0;
         end else if (step) begin
            state_q <= {state_q[1:0], word_i[state_q]};  // step to predecessor
            cnt_q   <= cnt_q + 1'b1;
            if (last) begin
               if (phase_q == viterbi_mem_pkg::TB_TRAIN)
                  phase_q <= viterbi_mem_pkg::TB_DECODE;
               else
                  phase_q <= viterbi_mem_pkg::TB_IDLE;
            end
         end
      end
   end

   // newest input bit sits in the state msb
   always_ff @(posedge clk) begin
      if (word_valid_i)
         bit_o <= state_q[2];
   end

endmodule

`default_nettype wire

//--- output_reorder.sv
`timescale 1ns/1ps
`default_nettype none

module output_reorder #(
   parameter int TB_LEN = 16
) (
   input  wire  clk,
   input  wire  rst,
   input  wire  enable_i,
   input  wire  bit0_i,
   input  wire  bit_valid0_i,
   input  wire  bit1_i,
   input  wire  bit_valid1_i,
   output logic d_out_o,
   output logic d_valid_o
);

   localparam int CNT_W = $clog2(TB_LEN);

   logic [TB_LEN-1:0] half_q [2];  // two block buffers
   logic              fill_half;   // half being written
   logic [CNT_W-1:0]  wr_addr;     // descending
   logic [CNT_W-1:0]  rd_addr;     // ascending
   logic              rd_active;
   logic              in_bit;
   logic              in_vld;
   logic              half_done;

   // only one traceback unit decodes at a time
   assign in_vld    = bit_valid0_i | bit_valid1_i;
   assign in_bit    = bit_valid0_i ? bit0_i : bit1_i;
   assign half_done = in_vld && (wr_addr == '0);

   always_ff @(posedge clk) begin
      if (in_vld)
         half_q[fill_half][wr_addr] <= in_bit;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         fill_half <= 1'b0;
         wr_addr   <= CNT_W'(TB_LEN - 1);
         rd_addr   <= '0;
         rd_active <= 1'b0;
      end else if (!enable_i) begin
         fill_half <= 1'b0;
         wr_addr   <= CNT_W'(TB_LEN - 1);
         rd_addr   <= '0;
         rd_active <= 1'b0;
      end else begin
         if (in_vld)
            wr_addr <= wr_addr - 1'b1;
         if (half_done) begin
            fill_half <= ~fill_half;  // swap halves
            rd_addr   <= '0;
            rd_active <= 1'b1;
         end else if (rd_active) begin
            rd_addr <= rd_addr + 1'b1;
            if (rd_addr == CNT_W'(TB_LEN - 1))
               rd_active <= 1'b0;     // no new block ready
         end
      end
   end

   // read the half that is not filling
   assign d_out_o   = half_q[~fill_half][rd_addr];
   assign d_valid_o = rd_active;

endmodule

`default_nettype wire

//--- viterbi_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module viterbi_decoder #(
   parameter int TB_LEN = 16,
   parameter int PM_W   = 8
) (
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             enable_i,
   input  wire  viterbi_code_pkg::symbol_t symbol_i,
   output logic                            d_out_o,
   output logic                            d_valid_o
);

   localparam int NS = viterbi_code_pkg::NUM_STATES;

   viterbi_code_pkg::bm_t [NS-1:0] bm0;
   viterbi_code_pkg::bm_t [NS-1:0] bm1;
   logic                           bm_valid;
   viterbi_code_pkg::decision_t    dec;
   logic                           dec_valid;
   logic                           start0;
   logic                           start1;
   viterbi_code_pkg::decision_t    word0;
   viterbi_code_pkg::decision_t    word1;
   logic                           word_valid0;
   logic                           word_valid1;
   logic                           bit0;
   logic                           bit1;
   logic                           bit_valid0;
   logic                           bit_valid1;

   // ------------------------------
   // metric path
   // ------------------------------
   branch_metric u_bm (
      .clk        (clk),
      .rst        (rst),
      .enable_i   (enable_i),
      .symbol_i   (symbol_i),
      .bm0_o      (bm0),
      .bm1_o      (bm1),
      .bm_valid_o (bm_valid)
   );

   acs_array #(.PM_W(PM_W)) u_acs (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .bm0_i       (bm0),
      .bm1_i       (bm1),
      .bm_valid_i  (bm_valid),
      .dec_o       (dec),
      .dec_valid_o (dec_valid)
   );

   // ------------------------------
   // survivor path
   // ------------------------------
   survivor_mem #(.TB_LEN(TB_LEN)) u_smem (
      .clk           (clk),
      .rst           (rst),
      .enable_i      (enable_i),
      .dec_i         (dec),
      .dec_valid_i   (dec_valid),
      .start0_o      (start0),
      .start1_o      (start1),
      .word0_o       (word0),
      .word1_o       (word1),
      .word_valid0_o (word_valid0),
      .word_valid1_o (word_valid1)
   );

   traceback_unit #(.TB_LEN(TB_LEN)) u_tbu_0 (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .start_i      (start0),
      .word_i       (word0),
      .word_valid_i (word_valid0),
      .bit_o        (bit0),
      .bit_valid_o  (bit_valid0)
   );

   traceback_unit #(.TB_LEN(TB_LEN)) u_tbu_1 (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .start_i      (start1),
      .word_i       (word1),
      .word_valid_i (word_valid1),
      .bit_o        (bit1),
      .bit_valid_o  (bit_valid1)
   );

   output_reorder #(.TB_LEN(TB_LEN)) u_reorder (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .bit0_i       (bit0),
      .bit_valid0_i (bit_valid0),
      .bit1_i       (bit1),
      .bit_valid1_i (bit_valid1),
      .d_out_o      (d_out_o),
      .d_valid_o    (d_valid_o)
   );

endmodule

`default_nettype wire

//--- tb_viterbi_tasks.svh
`ifndef TB_VITERBI_TASKS_SVH
`define TB_VITERBI_TASKS_SVH

// ------------------------------
// encoder and stimulus helpers
// ------------------------------

// parity of {data bit, history} under each generator mask
function automatic viterbi_code_pkg::symbol_t encode_pair(input logic b, input logic [2:0] hist);
   logic [3:0] sr;
   logic       p0;
   logic       p1;
   sr = {b, hist};
   p0 = 1'b0;
   p1 = 1'b0;
   for (int k = 0; k < 4; k++) begin
      if (viterbi_code_pkg::GEN0[k])
         p0 = p0 ^ sr[k];
      if (viterbi_code_pkg::GEN1[k])
         p1 = p1 ^ sr[k];
   end
   return {p0, p1};
endfunction

task automatic fill_random(input int n_sym);
   for (int i = 0; i < n_sym; i++)
      stream_bits[i] = 1'($urandom() % 2);
endtask

// outputs are registered, so the falling edge sees them settled
task automatic check_output();
   logic exp_bit;
   if (i_dut.u_acs.norm)
      norm_cnt++;
   if (d_valid_o) begin
      out_cnt++;
      seen_valid = 1'b1;
      if (exp_q.size() == 0) begin
         errors++;
         $display("decoded bit %0d came out with no sent bit left to match", out_cnt - 1);
      end else begin
         exp_bit = exp_q.pop_front();
         if (d_out_o !== exp_bit) begin
            errors++;
            $display("Fail d_out_o bit %0d: expected 0x%0h, got 0x%0h",
                     out_cnt - 1, exp_bit, d_out_o);
         end
      end
   end else if (seen_valid && enable_i) begin
      errors++;
      $display("d_valid_o dropped after %0d bits while enable_i was high", out_cnt);
      seen_valid = 1'b0;  // report each gap once
   end
endtask

task automatic drive_cycle(input logic en, input viterbi_code_pkg::symbol_t sym);
   @(negedge clk);
   check_output();
   enable_i = en;
   symbol_i = sym;
endtask

task automatic send_symbol(input int idx, input int flip_period);
   logic                      b;
   int                        pos;
   viterbi_code_pkg::symbol_t sym;
   b         = stream_bits[idx];
   sym       = encode_pair(b, enc_state);
   enc_state = {b, enc_state[2:1]};
   if (flip_period > 0 && (idx % flip_period) == flip_period - 1) begin
      pos      = (idx / flip_period) % 2;  // alternate the hit bit
      sym[pos] = ~sym[pos];
   end
   drive_cycle(1'b1, sym);
   exp_q.push_back(b);
endtask

// encoder restarts in state 0 with every enable rise
task automatic send_stream(input int n_sym, input int flip_period);
   int i;
   int waited;
   enc_state  = '0;
   out_cnt    = 0;
   seen_valid = 1'b0;
   exp_q.delete();
   i      = 0;
   waited = 0;
   while (!seen_valid && i < n_sym && waited < 6 * TB_LEN) begin
      send_symbol(i, flip_period);
      i++;
      waited++;
   end
   if (!seen_valid) begin
      errors++;
      $display("timeout: no decoded bit after %0d symbols", waited);
   end
   while (i < n_sym) begin
      send_symbol(i, flip_period);
      i++;
   end
endtask

// enable low discards whatever is still in flight
task automatic end_stream(input int hold);
   int waited;
   drive_cycle(1'b0, 2'b00);
   waited = 0;
   while (d_valid_o && waited < 2) begin
      drive_cycle(1'b0, 2'b00);
      waited++;
   end
   if (d_valid_o) begin
      errors++;
      $display("d_valid_o still high 2 cycles after enable_i fell");
   end
   for (int c = 0; c < hold; c++) begin
      drive_cycle(1'b0, 2'b00);
      if (d_valid_o) begin
         errors++;
         $display("d_valid_o rose again while enable_i was low");
      end
   end
   exp_q.delete();
   seen_valid = 1'b0;
endtask

task automatic check_bit_count(input int n_sym);
   if (out_cnt < n_sym - 6 * TB_LEN) begin
      errors++;
      $display("only %0d decoded bits came out of %0d symbols", out_cnt, n_sym);
   end
endtask

task automatic report_test(input string name, input int err_before);
   tests_run++;
   if (errors == err_before) begin
      $display("test %s: ok, %0d bits decoded", name, out_cnt);
   end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
   end
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic check_idle_after_reset();
   int err_before;
   err_before = errors;
   out_cnt    = 0;
   for (int c = 0; c < 50; c++) begin
      drive_cycle(1'b0, 2'b00);
      if (d_valid_o) begin
         errors++;
         $display("d_valid_o high in idle cycle %0d after reset", c);
      end
   end
   report_test("idle after reset", err_before);
endtask

task automatic decode_clean_stream();
   int err_before;
   err_before = errors;
   fill_random(200);
   send_stream(200, 0);
   end_stream(4);
   check_bit_count(200);
   report_test("clean stream", err_before);
endtask

task automatic decode_noisy_stream();
   int err_before;
   err_before = errors;
   send_stream(200, 16);  // one hit symbol bit per 16 symbols
   end_stream(4);
   check_bit_count(200);
   report_test("noisy stream", err_before);
endtask

task automatic restart_after_enable_drop();
   int err_before;
   err_before = errors;
   fill_random(100);
   send_stream(100, 0);   // drop lands inside a block
   end_stream(20);
   fill_random(120);
   send_stream(120, 0);
   end_stream(4);
   check_bit_count(120);
   report_test("enable drop and restart", err_before);
endtask

task automatic run_long_noisy_stream();
   int err_before;
   err_before = errors;
   norm_cnt   = 0;
   fill_random(1800);
   send_stream(1800, 12);
   end_stream(4);
   check_bit_count(1800);
   if (norm_cnt == 0) begin
      errors++;
      $display("path metrics were never normalized during the long stream");
   end
   report_test("metric normalization", err_before);
endtask

`endif

//--- tb_viterbi_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_viterbi_decoder;

   localparam int TB_LEN  = 16;
   localparam int PM_W    = 8;
   localparam int MAX_SYM = 2000;

   logic                      clk = 1'b0;
   logic                      rst;
   logic                      enable_i;
   viterbi_code_pkg::symbol_t symbol_i;
   logic                      d_out_o;
   logic                      d_valid_o;

   // ------------------------------
   // reference encoder and scoreboard
   // ------------------------------
   logic [2:0] enc_state;              // last three data bits, newest in bit 2
   logic       stream_bits [MAX_SYM];  // data of the current stream
   logic       exp_q [$];              // sent bits not yet decoded
   int         out_cnt;                // decoded bits seen in this stream
   int         norm_cnt;               // cycles with metric normalization
   logic       seen_valid;
   int         errors;
   int         tests_run;
   int         tests_failed;

   always #5 clk = ~clk;

   viterbi_decoder #(
      .TB_LEN (TB_LEN),
      .PM_W   (PM_W)
   ) i_dut (
      .clk       (clk),
      .rst       (rst),
      .enable_i  (enable_i),
      .symbol_i  (symbol_i),
      .d_out_o   (d_out_o),
      .d_valid_o (d_valid_o)
   );

   `include "tb_viterbi_tasks.svh"

   initial begin
      rst          = 1'b0;
      enable_i     = 1'b0;
      symbol_i     = '0;
      enc_state    = '0;
      out_cnt      = 0;
      norm_cnt     = 0;
      seen_valid   = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(32'h00c4_2984));

      // reset held for 8 cycles, released away from the rising edge
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;

      check_idle_after_reset();
      decode_clean_stream();
      decode_noisy_stream();   // same data as the clean stream
      restart_after_enable_drop();
      run_long_noisy_stream();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
viterbi_code_pkg.sv
viterbi_mem_pkg.sv
branch_metric.sv
acs_array.sv
survivor_mem.sv
traceback_unit.sv
output_reorder.sv
viterbi_decoder.sv
tb_viterbi_decoder.sv

//--- Makefile
# Verilator build and run for the Viterbi decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_viterbi_decoder
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) tb_viterbi_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
